// ==== common/v810_pkg.sv ====
package v810_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths

    typedef logic [31:0] word_t;        // Data word and address
    typedef logic [15:0] insn_t;        // One instruction halfword
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'hFFFF_FFF0;

    //////////////////////////////////////////////////////////////////////
    // Opcodes, bits 15..10 of the halfword

    // Bcond is 100_xxxx and is decoded by its top three bits
    typedef enum logic [5:0] {
        OP_MOV   = 6'b000000,
        OP_ADD   = 6'b000001,
        OP_SUB   = 6'b000010,
        OP_CMP   = 6'b000011,
        OP_SHL   = 6'b000100,
        OP_SHR   = 6'b000101,
        OP_SAR   = 6'b000111,
        OP_OR    = 6'b001100,
        OP_AND   = 6'b001101,
        OP_XOR   = 6'b001110,
        OP_NOT   = 6'b001111,
        OP_MOV_I = 6'b010000,   // Format II from here on
        OP_ADD_I = 6'b010001,
        OP_SETF  = 6'b010010,
        OP_CMP_I = 6'b010011,
        OP_SHL_I = 6'b010100,
        OP_SHR_I = 6'b010101,
        OP_SAR_I = 6'b010111
    } op_t;

    // Same encoding as the low opcode bits of the ALU instructions
    typedef enum logic [3:0] {
        ALU_MOV = 4'b0000,
        ALU_ADD = 4'b0001,
        ALU_SUB = 4'b0010,
        ALU_SHL = 4'b0100,
        ALU_SHR = 4'b0101,
        ALU_SAR = 4'b0111,
        ALU_OR  = 4'b1100,
        ALU_AND = 4'b1101,
        ALU_XOR = 4'b1110,
        ALU_NOT = 4'b1111
    } aluop_t;

    // Base conditions; a fourth bit above these inverts the test
    typedef enum logic [2:0] {
        BCOND_V, BCOND_C, BCOND_Z, BCOND_NH, BCOND_S, BCOND_T, BCOND_LT, BCOND_LTE
    } bcond_t;

    //////////////////////////////////////////////////////////////////////
    // Flags

    typedef logic [3:0] aluflags_t;

    localparam int FL_CY = 3;
    localparam int FL_OV = 2;
    localparam int FL_S  = 1;
    localparam int FL_Z  = 0;

    localparam aluflags_t FLAGS_ALL   = 4'b1111;
    localparam aluflags_t FLAGS_NO_CY = 4'b0111;   // Logic ops and shifts

endpackage

// ==== hdl/v810_fetch.sv ====
`timescale 1ns/1ps

module v810_fetch
    import v810_pkg::*;
(
    input  logic  CLK,
    input  logic  rst,
    input  word_t ID,
    input  logic  IACK,
    input  logic  id_stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t IA,
    output logic  IREQ,
    output logic  if_valid,
    output word_t if_pc,
    output insn_t if_ir
);
    word_t pc;              // Address on the bus, steady while IREQ waits
    word_t redirect_pc;
    logic  discard;         // Request in flight was overtaken by a branch
    logic  done;
    logic  take;
    logic  if_valid_nxt;

    assign IA   = pc;
    assign done = IREQ & IACK;
    assign take = done & ~discard & ~branch_taken;

    always_comb begin
        if_valid_nxt = if_valid & id_stall;     // Held while decode stalls
        if (branch_taken)
            if_valid_nxt = 1'b0;
        else if (take)
            if_valid_nxt = 1'b1;
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc       <= RESET_PC;
            IREQ     <= 1'b0;
            discard  <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if_valid <= if_valid_nxt;
            // New request only once the IF/ID slot is known to be free
            IREQ <= (IREQ & ~IACK) | ~if_valid_nxt;
            if (done) begin
                discard <= 1'b0;
                if (branch_taken)
                    pc <= branch_target;
                else if (discard)
                    pc <= redirect_pc;
                else
                    pc <= pc + 32'd2;
            end else if (branch_taken) begin
                if (IREQ)
                    discard <= 1'b1;    // Let it finish, drop its data
                else
                    pc <= branch_target;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (branch_taken)
            redirect_pc <= branch_target;
        if (take) begin
            if_pc <= pc;
            if_ir <= pc[1] ? ID[31:16] : ID[15:0];
        end
    end

    a_ia_stable: assert property (@(posedge CLK) disable iff (rst)
        IREQ && !IACK |=> IREQ && $stable(IA));

endmodule

// ==== hdl/v810_decode.sv ====
`timescale 1ns/1ps

module v810_decode
    import v810_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       if_valid,
    input  word_t      if_pc,
    input  insn_t      if_ir,
    input  logic       branch_taken,
    input  word_t      rf_rd1,
    input  word_t      rf_rd2,
    output logic       id_stall,
    output reg_addr_t  rf_ra1,
    output reg_addr_t  rf_ra2,
    output logic       ex_valid,
    output word_t      ex_pc,
    output insn_t      ex_ir,
    output word_t      ex_rd1,
    output word_t      ex_rd2,
    output reg_addr_t  ex_wa,
    output logic       ex_we,
    output aluop_t     ex_aluop,
    output logic       ex_src1_imm5,
    output logic       ex_branch,
    output logic       ex_setf,
    output logic [3:0] ex_bcond,
    output aluflags_t  ex_flag_mask
);
    logic       dec_valid;
    logic       dec_we;
    logic       dec_branch;
    logic       dec_setf;
    aluop_t     dec_aluop;
    logic [3:0] dec_bcond;
    aluflags_t  dec_mask;
    logic       haz_data;
    logic       haz_flag;
    logic       load;

    //////////////////////////////////////////////////////////////////////
    // Opcode decode

    always_comb begin
        dec_valid  = if_valid;
        dec_we     = 1'b0;
        dec_branch = 1'b0;
        dec_setf   = 1'b0;
        dec_aluop  = ALU_MOV;
        dec_bcond  = if_ir[3:0];            // SETF condition
        dec_mask   = '0;
        rf_ra1     = '0;
        rf_ra2     = '0;
        if (if_ir[15:13] == 3'b100) begin
            dec_branch = 1'b1;              // PC + disp9
            dec_aluop  = ALU_ADD;
            dec_bcond  = if_ir[12:9];
        end else begin
            case (if_ir[15:10])
                OP_MOV, OP_NOT: begin
                    dec_we    = 1'b1;
                    dec_aluop = aluop_t'(if_ir[13:10]);
                    rf_ra1    = if_ir[4:0];
                end
                OP_ADD, OP_SUB, OP_SHL, OP_SHR, OP_SAR, OP_OR, OP_AND, OP_XOR: begin
                    dec_we    = 1'b1;
                    dec_aluop = aluop_t'(if_ir[13:10]);
                    rf_ra1    = if_ir[4:0];
                    rf_ra2    = if_ir[9:5];
                end
                OP_MOV_I, OP_ADD_I, OP_SHL_I, OP_SHR_I, OP_SAR_I: begin
                    dec_we    = 1'b1;
                    dec_aluop = aluop_t'(if_ir[13:10]);
                    rf_ra2    = if_ir[9:5];     // Unused by MOV
                end
                OP_CMP, OP_CMP_I: begin
                    dec_aluop = ALU_SUB;        // Flags only
                    rf_ra1    = if_ir[14] ? 5'd0 : if_ir[4:0];
                    rf_ra2    = if_ir[9:5];
                end
                OP_SETF: begin
                    dec_we   = 1'b1;
                    dec_setf = 1'b1;
                end
                default: dec_valid = 1'b0;      // Undefined opcode becomes a bubble
            endcase
            if (dec_aluop == ALU_ADD || dec_aluop == ALU_SUB)
                dec_mask = FLAGS_ALL;
            else if (dec_aluop != ALU_MOV)
                dec_mask = FLAGS_NO_CY;
        end
        if (if_ir[9:5] == 5'd0)
            dec_we = 1'b0;                      // r0 stays zero
    end

    //////////////////////////////////////////////////////////////////////
    // Hazard detection against EX

    // A result in WB reaches decode through the register file
    assign haz_data = ex_we & ((ex_wa == rf_ra1) | (ex_wa == rf_ra2));
    assign haz_flag = |ex_flag_mask &
                      ((dec_branch & (dec_bcond[2:0] != BCOND_T)) | dec_setf);
    assign id_stall = if_valid & (haz_data | haz_flag);
    assign load     = dec_valid & ~id_stall & ~branch_taken;

    always_ff @(posedge CLK) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            ex_we        <= 1'b0;
            ex_branch    <= 1'b0;
            ex_setf      <= 1'b0;
            ex_flag_mask <= '0;
        end else begin
            ex_valid     <= load;
            ex_we        <= load & dec_we;
            ex_branch    <= load & dec_branch;
            ex_setf      <= load & dec_setf;
            ex_flag_mask <= load ? dec_mask : '0;
        end
    end

    always_ff @(posedge CLK) begin
        ex_pc        <= if_pc;
        ex_ir        <= if_ir;
        ex_rd1       <= rf_rd1;
        ex_rd2       <= rf_rd2;
        ex_wa        <= if_ir[9:5];
        ex_aluop     <= dec_aluop;
        ex_src1_imm5 <= if_ir[14];
        ex_bcond     <= dec_bcond;
    end

    // A bubble in EX carries no register write
    a_bubble_no_write: assert property (@(posedge CLK) disable iff (rst)
        !ex_valid |-> !ex_we);

endmodule

// ==== hdl/v810_regfile.sv ====
`timescale 1ns/1ps

module v810_regfile
    import v810_pkg::*;
(
    input  logic      CLK,
    input  reg_addr_t rf_ra1,
    input  reg_addr_t rf_ra2,
    input  logic      retire_we,
    input  reg_addr_t retire_wa,
    input  word_t     retire_wd,
    output word_t     rf_rd1,
    output word_t     rf_rd2
);
    word_t mem [32];

    initial begin
        mem = '{default: '0};
    end

    // Write in WB shows up on a read in the same cycle
    assign rf_rd1 = (rf_ra1 == 5'd0)                      ? '0 :
                    (retire_we && retire_wa == rf_ra1)    ? retire_wd : mem[rf_ra1];
    assign rf_rd2 = (rf_ra2 == 5'd0)                      ? '0 :
                    (retire_we && retire_wa == rf_ra2)    ? retire_wd : mem[rf_ra2];

    always_ff @(posedge CLK) begin
        if (retire_we)
            mem[retire_wa] <= retire_wd;
    end

    a_no_r0_write: assert property (@(posedge CLK) retire_we |-> retire_wa != 5'd0);

endmodule

// ==== exec/v810_alu.sv ====
`timescale 1ns/1ps

module v810_alu
    import v810_pkg::*;
(
    input  aluop_t    ex_aluop,
    input  logic      ex_src1_imm5,
    input  insn_t     ex_ir,
    input  word_t     ex_rd1,
    input  word_t     ex_rd2,
    input  word_t     ex_pc,
    input  logic      ex_branch,
    input  logic      ex_setf,
    input  logic      cond_match,
    output word_t     alu_out,
    output aluflags_t alu_flags
);
    word_t op1;
    word_t op2;
    word_t imm5_ext;
    logic  imm5_se;

    // MOV, ADD and CMP sign-extend imm5, the shifts zero-extend it
    assign imm5_se  = ex_aluop < ALU_SHL;
    assign imm5_ext = imm5_se ? 32'($signed(ex_ir[4:0])) : 32'(ex_ir[4:0]);

    always_comb begin
        if (ex_branch)
            op1 = ex_pc;
        else if (ex_setf)
            op1 = {31'd0, cond_match};
        else if (ex_src1_imm5)
            op1 = imm5_ext;
        else
            op1 = ex_rd1;
    end

    assign op2 = ex_branch ? 32'($signed(ex_ir[8:0])) : ex_rd2;   // disp9

    always_comb begin
        alu_flags = '0;
        alu_out   = op1;
        case (ex_aluop)
            ALU_ADD: begin
                {alu_flags[FL_CY], alu_out} = op2 + op1;
                alu_flags[FL_OV] = (op1[31] == op2[31]) & (op2[31] != alu_out[31]);
            end
            ALU_SUB: begin
                {alu_flags[FL_CY], alu_out} = op2 - op1;   // Borrow
                alu_flags[FL_OV] = (op1[31] != op2[31]) & (op2[31] != alu_out[31]);
            end
            ALU_SHL: {alu_flags[FL_CY], alu_out} = {1'b0, op2} << op1[4:0];
            ALU_SHR: {alu_out, alu_flags[FL_CY]} = {op2, 1'b0} >> op1[4:0];
            ALU_SAR: {alu_out, alu_flags[FL_CY]} = $signed({op2, 1'b0}) >>> op1[4:0];
            ALU_OR:  alu_out = op1 | op2;
            ALU_AND: alu_out = op1 & op2;
            ALU_XOR: alu_out = op1 ^ op2;
            ALU_NOT: alu_out = ~op1;
            default: alu_out = op1;     // MOV
        endcase
        alu_flags[FL_Z] = ~|alu_out;
        alu_flags[FL_S] = alu_out[31];
    end

endmodule

// ==== exec/v810_exec.sv ====
`timescale 1ns/1ps

module v810_exec
    import v810_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       ex_valid,
    input  word_t      ex_pc,
    input  insn_t      ex_ir,
    input  word_t      ex_rd1,
    input  word_t      ex_rd2,
    input  reg_addr_t  ex_wa,
    input  logic       ex_we,
    input  aluop_t     ex_aluop,
    input  logic       ex_src1_imm5,
    input  logic       ex_branch,
    input  logic       ex_setf,
    input  logic [3:0] ex_bcond,
    input  aluflags_t  ex_flag_mask,
    output logic       branch_taken,
    output word_t      branch_target,
    output aluflags_t  psw_flags,
    output logic       retire_valid,
    output logic       retire_we,
    output reg_addr_t  retire_wa,
    output word_t      retire_wd
);
    logic      cond_base;
    logic      cond_match;
    word_t     alu_out;
    aluflags_t alu_flags;

    v810_alu u_alu (.*);

    //////////////////////////////////////////////////////////////////////
    // Condition test, shared by Bcond and SETF

    always_comb begin
        cond_base = 1'b0;
        case (bcond_t'(ex_bcond[2:0]))
            BCOND_V:   cond_base = psw_flags[FL_OV];
            BCOND_C:   cond_base = psw_flags[FL_CY];                    // Lower
            BCOND_Z:   cond_base = psw_flags[FL_Z];
            BCOND_NH:  cond_base = psw_flags[FL_CY] | psw_flags[FL_Z];
            BCOND_S:   cond_base = psw_flags[FL_S];
            BCOND_T:   cond_base = 1'b1;
            BCOND_LT:  cond_base = psw_flags[FL_S] ^ psw_flags[FL_OV];
            BCOND_LTE: cond_base = (psw_flags[FL_S] ^ psw_flags[FL_OV]) | psw_flags[FL_Z];
            default:   cond_base = 1'b0;
        endcase
    end

    assign cond_match    = cond_base ^ ex_bcond[3];
    assign branch_taken  = ex_valid & ex_branch & cond_match;
    assign branch_target = alu_out;

    //////////////////////////////////////////////////////////////////////
    // PSW flags and EX/WB

    always_ff @(posedge CLK) begin
        if (rst) begin
            psw_flags    <= '0;
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            psw_flags    <= (psw_flags & ~ex_flag_mask) | (alu_flags & ex_flag_mask);
            retire_valid <= ex_valid;
            retire_we    <= ex_we;
        end
    end

    always_ff @(posedge CLK) begin
        retire_wa <= ex_wa;
        retire_wd <= alu_out;
    end

endmodule

// ==== hdl/v810_core.sv ====
`timescale 1ns/1ps

module v810_core
    import v810_pkg::*;
(
    input  logic      CLK,
    input  logic      rst,
    input  word_t     ID,
    input  logic      IACK,
    output word_t     IA,
    output logic      IREQ,
    output logic      retire_valid,
    output logic      retire_we,
    output reg_addr_t retire_wa,
    output word_t     retire_wd,
    output aluflags_t psw_flags
);
    // IF/ID
    logic       if_valid;
    word_t      if_pc;
    insn_t      if_ir;
    logic       id_stall;

    // Register read
    reg_addr_t  rf_ra1;
    reg_addr_t  rf_ra2;
    word_t      rf_rd1;
    word_t      rf_rd2;

    // ID/EX
    logic       ex_valid;
    word_t      ex_pc;
    insn_t      ex_ir;
    word_t      ex_rd1;
    word_t      ex_rd2;
    reg_addr_t  ex_wa;
    logic       ex_we;
    aluop_t     ex_aluop;
    logic       ex_src1_imm5;
    logic       ex_branch;
    logic       ex_setf;
    logic [3:0] ex_bcond;
    aluflags_t  ex_flag_mask;

    // Redirect from EX
    logic       branch_taken;
    word_t      branch_target;

    v810_fetch   u_fetch   (.*);
    v810_decode  u_decode  (.*);
    v810_regfile u_regfile (.*);
    v810_exec    u_exec    (.*);

endmodule

// ==== dv/v810_model.svh ====
//////////////////////////////////////////////////////////////////////
// Random source, Galois form, one step per bit

localparam logic [31:0] LFSR_SEED = 32'h7110_22ee;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;     // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_state = LFSR_SEED;

function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v          = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

//////////////////////////////////////////////////////////////////////
// Architectural state, one instruction per step

word_t     m_regs [32] = '{default: '0};
aluflags_t m_flags     = '0;
word_t     m_pc        = RESET_PC;

// Sixteen conditions, bit 3 negates
function automatic logic cond_holds(logic [3:0] c, aluflags_t f);
    logic r;
    case (c[2:0])
        3'd0:    r = f[FL_OV];
        3'd1:    r = f[FL_CY];
        3'd2:    r = f[FL_Z];
        3'd3:    r = f[FL_CY] | f[FL_Z];     // Not higher
        3'd4:    r = f[FL_S];
        3'd5:    r = 1'b1;
        3'd6:    r = f[FL_S] ^ f[FL_OV];
        default: r = (f[FL_S] ^ f[FL_OV]) | f[FL_Z];
    endcase
    return r ^ c[3];
endfunction

task automatic model_step(output logic we, output reg_addr_t wa, output word_t wd,
                          output logic branch);
    insn_t       ir;
    op_t         op;
    word_t       a;
    word_t       b;
    word_t       x;
    word_t       res;
    logic [32:0] wide;
    logic        wr;
    logic        ov;
    logic [1:0]  kind;      // 0 keeps flags, 1 sets all, 2 all but carry

    ir     = m_pc[1] ? prog[m_pc[9:2]][31:16] : prog[m_pc[9:2]][15:0];
    op     = op_t'(ir[15:10]);
    a      = m_regs[ir[4:0]];
    b      = m_regs[ir[9:5]];
    x      = op[4] ? {{27{ir[4]}}, ir[4:0]} : a;
    if (op == OP_SHL_I || op == OP_SHR_I || op == OP_SAR_I)
        x = {27'd0, ir[4:0]};           // Unsigned shift count
    res    = '0;
    wide   = '0;
    wr     = 1'b0;
    ov     = 1'b0;
    kind   = 2'd0;
    branch = (ir[15:13] == 3'b100);
    if (branch) begin
        m_pc = m_pc + (cond_holds(ir[12:9], m_flags) ? {{23{ir[8]}}, ir[8:0]} : 32'd2);
    end else begin
        wr   = 1'b1;
        kind = 2'd2;
        case (op)
            OP_MOV, OP_MOV_I: begin
                res  = x;
                kind = 2'd0;
            end
            OP_ADD, OP_ADD_I: begin
                wide = {1'b0, b} + {1'b0, x};
                ov   = (b[31] == x[31]) && (wide[31] != b[31]);
                res  = wide[31:0];
                kind = 2'd1;
            end
            OP_SUB, OP_CMP, OP_CMP_I: begin
                wide = {1'b0, b} - {1'b0, x};   // Bit 32 is the borrow
                ov   = (b[31] != x[31]) && (wide[31] != b[31]);
                res  = wide[31:0];
                wr   = (op == OP_SUB);
                kind = 2'd1;
            end
            OP_SHL, OP_SHL_I: res = b << x[4:0];
            OP_SHR, OP_SHR_I: res = b >> x[4:0];
            OP_SAR, OP_SAR_I: res = $signed(b) >>> x[4:0];
            OP_OR:            res = b | a;
            OP_AND:           res = b & a;
            OP_XOR:           res = b ^ a;
            OP_NOT:           res = ~a;
            OP_SETF: begin
                res  = {31'd0, cond_holds(ir[3:0], m_flags)};
                kind = 2'd0;
            end
            default:          wr = 1'b0;
        endcase
        m_pc = m_pc + 32'd2;
    end
    if (kind != 2'd0) begin
        m_flags[FL_Z]  = (res == 32'd0);
        m_flags[FL_S]  = res[31];
        m_flags[FL_OV] = ov;
    end
    if (kind == 2'd1)
        m_flags[FL_CY] = wide[32];
    we = wr && (ir[9:5] != 5'd0);
    if (we)
        m_regs[ir[9:5]] = res;
    wa = ir[9:5];
    wd = res;
endtask

// ==== dv/v810_core_tb.sv ====
`timescale 1ns/1ps

module v810_core_tb
    import v810_pkg::*;
;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_RETIRE     = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_RETIRE * 16;

    logic      CLK;
    logic      rst;
    word_t     ID;
    logic      IACK;
    word_t     IA;
    logic      IREQ;
    logic      retire_valid;
    logic      retire_we;
    reg_addr_t retire_wa;
    word_t     retire_wd;
    aluflags_t psw_flags;

    word_t     prog [256];      // Two halfwords per word, low one first

    logic      pending;
    logic [1:0] delay_left;
    int        cycles  = 0;
    int        retired = 0;
    logic      req_seen = 1'b0;
    logic      ack_seen = 1'b0;
    logic      wait_prev = 1'b0;
    word_t     ia_prev;
    logic      exp_we;
    reg_addr_t exp_wa;
    word_t     exp_wd;
    logic      exp_branch;

    `include "v810_model.svh"

    v810_core dut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program image

    function automatic insn_t random_insn();
        logic [4:0] sel;
        logic [4:0] r1;
        logic [4:0] r2;
        logic [4:0] imm;
        logic [8:0] disp;
        op_t        op;

        sel = 5'(rand_bits(5));
        r1  = 5'(rand_bits(3));     // r0 to r7 only, so hazards are frequent
        r2  = 5'(rand_bits(3));
        imm = 5'(rand_bits(5));
        if (sel >= 5'd28) begin
            disp = {8'(rand_bits(8)), 1'b0};
            if (disp == 9'd0)
                disp = 9'd4;        // No branch to itself
            return {3'b100, imm[3:0], disp};
        end
        if (sel >= 5'd25)
            return {OP_SETF, r2, 1'b0, imm[3:0]};
        case (sel % 5'd17)
            5'd0:    op = OP_MOV;
            5'd1:    op = OP_ADD;
            5'd2:    op = OP_SUB;
            5'd3:    op = OP_CMP;
            5'd4:    op = OP_SHL;
            5'd5:    op = OP_SHR;
            5'd6:    op = OP_SAR;
            5'd7:    op = OP_OR;
            5'd8:    op = OP_AND;
            5'd9:    op = OP_XOR;
            5'd10:   op = OP_NOT;
            5'd11:   op = OP_MOV_I;
            5'd12:   op = OP_ADD_I;
            5'd13:   op = OP_CMP_I;
            5'd14:   op = OP_SHL_I;
            5'd15:   op = OP_SHR_I;
            default: op = OP_SAR_I;
        endcase
        return {op, r2, op[4] ? imm : r1};
    endfunction

    task automatic load_program();
        insn_t lo;
        insn_t hi;
        for (int i = 0; i < 256; i++) begin
            lo      = random_insn();
            hi      = random_insn();
            prog[i] = {hi, lo};
        end
    endtask

    function automatic logic [1:0] pick_delay();
        logic [1:0] r;
        r = 2'(rand_bits(2));
        return (r == 2'd3) ? 2'd2 : r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Instruction bus responder

    always @(posedge CLK) begin
        if (rst) begin
            IACK    <= 1'b0;
            pending <= 1'b0;
        end else if (pending) begin
            if (delay_left == 2'd0) begin
                IACK    <= 1'b1;
                ID      <= prog[IA[9:2]];
                pending <= 1'b0;
            end else begin
                delay_left <= delay_left - 2'd1;
            end
        end else begin
            IACK <= 1'b0;
            if (IREQ && !IACK) begin        // New request, not the one just acked
                pending    <= 1'b1;
                delay_left <= pick_delay();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks on the falling edge

    always @(negedge CLK) begin
        if (rst) begin
            if (cycles >= 1) begin
                check_value("IREQ", 32'(IREQ), 32'd0);
                check_value("retire_valid", 32'(retire_valid), 32'd0);
            end
        end else begin
            if (IREQ && !req_seen) begin
                check_value("IA", IA, RESET_PC);    // First fetch
                req_seen = 1'b1;
            end
            if (wait_prev)
                check_value("IA", IA, ia_prev);
            if (retire_valid) begin
                if (!ack_seen) begin
                    $display("An instruction retired before any fetch completed");
                    $display("Testbench failed");
                    $fatal(1, "early retire");
                end
                model_step(exp_we, exp_wa, exp_wd, exp_branch);
                check_value("retire_we", 32'(retire_we), 32'(exp_we));
                if (!exp_branch) begin
                    check_value("retire_wa", 32'(retire_wa), 32'(exp_wa));
                    check_value("retire_wd", retire_wd, exp_wd);
                end
                check_value("psw_flags", 32'(psw_flags), 32'(m_flags));
                retired = retired + 1;
            end
            if (IACK)
                ack_seen = 1'b1;
            wait_prev = IREQ && !IACK;
            ia_prev   = IA;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, NUM_RETIRE);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst  = 1'b1;
        IACK = 1'b0;
        ID   = '0;
        load_program();
        repeat (RESET_CYCLES) @(posedge CLK);
        rst <= 1'b0;
        wait (retired == NUM_RETIRE);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+dv
common/v810_pkg.sv
hdl/v810_fetch.sv
hdl/v810_decode.sv
hdl/v810_regfile.sv
exec/v810_alu.sv
exec/v810_exec.sv
hdl/v810_core.sv
dv/v810_core_tb.sv
